//--- source/int_pkg.sv
// Shared widths, bundles, enums and fixed 6502 addresses, imported by every unit of the design
`default_nettype none

package int_pkg;

	////////////////////
	// Widths
	////////////////////

	// CPU address bus
	typedef logic [15:0] addr_t;
	// Data bus and 8-bit registers
	typedef logic [7:0] byte_t;

	////////////////////
	// Bundles
	////////////////////

	// Register set between engine and sequencer
	typedef struct packed {
		addr_t pc;
		byte_t status;
		byte_t sp;
	} cpu_regs_t;

	// One memory access, we high for a write
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  we;
	} bus_req_t;

	////////////////////
	// Enums
	////////////////////

	// Winning interrupt source
	typedef enum logic [2:0] {
		cause_none,
		cause_reset,
		cause_nmi,
		cause_brk,
		cause_irq
	} int_cause_e;

	// Sequencer states
	typedef enum logic [3:0] {
		idle,
		handle_1,
		handle_2,
		handle_3,
		handle_4,
		return_1,
		return_2,
		return_3,
		return_4,
		finish
	} seq_state_e;

	// Vector low bytes, high byte sits at addr + 1
	localparam addr_t vec_nmi   = 16'hFFFA;
	localparam addr_t vec_reset = 16'hFFFC;
	localparam addr_t vec_irq   = 16'hFFFE;

	// Pages backed by RAM
	localparam byte_t stack_page = 8'h01;
	localparam byte_t vec_page   = 8'hFF;

	// Status register bits
	localparam int flag_i = 2;
	localparam int flag_b = 4;
	localparam int flag_r = 5;

endpackage

`default_nettype wire

//--- source/int_sources.sv
// Pending interrupt latches and priority encoder, feeds the winning cause to the sequencer
`timescale 1ns/1ns
`default_nettype none

module int_sources
	import int_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire        soft_reset_n,
	input  wire byte_t ppu_status,
	input  wire byte_t ppu_ctrl1,
	input  wire        brk,
	input  wire        irq_n,
	input  wire        status_i,
	input  wire        vec_fetch,
	input  wire int_cause_e fetch_cause,
	output int_cause_e cause
);

	// Pending flags
	logic reset_pend;
	logic nmi_pend;
	logic irq_pend;

	// Vertical blank only counts with NMI enabled in PPU control
	logic vblank_nmi;

	// Per-source clear from the vector fetch strobe
	logic clr_reset;
	logic clr_nmi;
	logic clr_irq;

	assign vblank_nmi = ppu_status[7] & ppu_ctrl1[7];

	assign clr_reset = vec_fetch && (fetch_cause == cause_reset);
	assign clr_nmi   = vec_fetch && (fetch_cause == cause_nmi);
	assign clr_irq   = vec_fetch && (fetch_cause == cause_irq);

	////////////////////
	// Latches
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			reset_pend <= 1'b0;
			nmi_pend   <= 1'b0;
			irq_pend   <= 1'b0;
		end else begin
			// Clear beats set in the same cycle
			if (clr_reset) begin
				reset_pend <= 1'b0;
			end else if (!soft_reset_n) begin
				reset_pend <= 1'b1;
			end

			if (clr_nmi) begin
				nmi_pend <= 1'b0;
			end else if (vblank_nmi) begin
				nmi_pend <= 1'b1;
			end

			// IRQ line is active low
			if (clr_irq) begin
				irq_pend <= 1'b0;
			end else if (!irq_n) begin
				irq_pend <= 1'b1;
			end
		end
	end

	////////////////////
	// Priority
	////////////////////

	// Reset, then NMI, then BRK, then IRQ under the I mask
	always_comb begin
		cause = cause_none;
		if (reset_pend) begin
			cause = cause_reset;
		end else if (nmi_pend) begin
			cause = cause_nmi;
		end else if (brk) begin
			// BRK ignores I
			cause = cause_brk;
		end else if (irq_pend && !status_i) begin
			cause = cause_irq;
		end
	end

endmodule

`default_nettype wire

//--- source/int_sequencer.sv
// Interrupt entry and RTI state machine, drives the bus while busy and hands back next registers
`timescale 1ns/1ns
`default_nettype none

module int_sequencer
	import int_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             start,
	input  wire             is_rti,
	input  wire             halt,
	input  wire cpu_regs_t  regs_in,
	input  wire int_cause_e cause,
	input  wire byte_t      rdata,
	output cpu_regs_t       regs_out,
	output bus_req_t        seq_req,
	output logic            vec_fetch,
	output int_cause_e      fetch_cause,
	output logic            busy,
	output logic            done,
	output logic            ie_dis
);

	seq_state_e state;

	// Cause and registers frozen at start
	int_cause_e cause_q;
	cpu_regs_t  regs_q;

	// Vector low byte, waits for the high byte
	byte_t vec_lo_q;

	// High on the first cycle of a state, rdata then belongs to the previous request
	logic  adv_q;
	byte_t rd_hold;
	byte_t rd_cur;

	// Derived values
	addr_t vec_addr;
	byte_t push_status;
	byte_t entry_status;
	byte_t pop_status;

	assign busy        = (state != idle);
	assign done        = (state == finish) && !halt;
	assign vec_fetch   = (state == handle_1) && !halt;
	assign fetch_cause = cause_q;

	////////////////////
	// Read data recovery
	////////////////////

	// A halted state keeps presenting its own address, so the earlier read is kept here
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			adv_q <= 1'b0;
		end else begin
			adv_q <= !halt;
		end
	end

	always_ff @(posedge clk) begin
		if (adv_q) begin
			rd_hold <= rdata;
		end
	end

	assign rd_cur = adv_q ? rdata : rd_hold;

	////////////////////
	// Vector and status values
	////////////////////

	// Vector picked from the live cause at start
	always_comb begin
		case (cause)
			cause_reset: vec_addr = vec_reset;
			cause_nmi:   vec_addr = vec_nmi;
			default:     vec_addr = vec_irq;
		endcase
	end

	always_comb begin
		push_status  = regs_q.status;
		entry_status = regs_q.status;
		// R always pushed as one, I set on entry
		push_status[flag_r]  = 1'b1;
		entry_status[flag_i] = 1'b1;
		if (cause_q == cause_brk) begin
			push_status[flag_b] = 1'b1;
		end else begin
			// Hardware interrupts push B clear
			push_status[flag_b]  = 1'b0;
			entry_status[flag_r] = 1'b0;
			entry_status[flag_b] = 1'b0;
		end
	end

	// Popped status loses R and B
	always_comb begin
		pop_status         = rd_cur;
		pop_status[flag_r] = 1'b0;
		pop_status[flag_b] = 1'b0;
	end

	// Payload captures
	always_ff @(posedge clk) begin
		if (!halt && state == idle && start) begin
			regs_q <= regs_in;
		end
		if (!halt && state == handle_2) begin
			vec_lo_q <= rd_cur;
		end
	end

	////////////////////
	// State machine
	////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= idle;
			cause_q  <= cause_none;
			regs_out <= '0;
			seq_req  <= '0;
			ie_dis   <= 1'b0;
		end else if (!halt) begin
			case (state)
				idle: begin
					seq_req.we <= 1'b0;
					if (start) begin
						// Default result is the unchanged register set
						regs_out <= regs_in;
						cause_q  <= cause;
						state    <= finish;
						if (ie_dis) begin
							// Inside a handler only RTI does anything
							if (is_rti) begin
								seq_req.addr <= {stack_page, byte_t'(regs_in.sp + 8'd1)};
								state        <= return_1;
							end
						end else if (cause != cause_none) begin
							seq_req.addr <= vec_addr;
							state        <= handle_1;
						end
					end
				end

				// Vector high byte address
				handle_1: begin
					seq_req.addr <= seq_req.addr + 16'd1;
					state        <= handle_2;
				end

				// Push PCH at sp
				handle_2: begin
					seq_req.addr  <= {stack_page, regs_q.sp};
					seq_req.wdata <= regs_q.pc[15:8];
					seq_req.we    <= 1'b1;
					state         <= handle_3;
				end

				// Vector complete, push PCL
				handle_3: begin
					regs_out.pc   <= {rd_cur, vec_lo_q};
					seq_req.addr  <= {stack_page, byte_t'(regs_q.sp - 8'd1)};
					seq_req.wdata <= regs_q.pc[7:0];
					ie_dis        <= 1'b1;
					state         <= handle_4;
				end

				// Push status, three bytes used
				handle_4: begin
					seq_req.addr    <= {stack_page, byte_t'(regs_q.sp - 8'd2)};
					seq_req.wdata   <= push_status;
					regs_out.status <= entry_status;
					regs_out.sp     <= byte_t'(regs_q.sp - 8'd3);
					state           <= finish;
				end

				return_1: begin
					seq_req.addr <= {stack_page, byte_t'(regs_q.sp + 8'd2)};
					state        <= return_2;
				end

				// Status arrives
				return_2: begin
					regs_out.status <= pop_status;
					regs_out.sp     <= byte_t'(regs_q.sp + 8'd3);
					seq_req.addr    <= {stack_page, byte_t'(regs_q.sp + 8'd3)};
					ie_dis          <= 1'b0;
					state           <= return_3;
				end

				return_3: begin
					regs_out.pc[7:0] <= rd_cur;
					state            <= return_4;
				end

				return_4: begin
					regs_out.pc[15:8] <= rd_cur;
					state             <= finish;
				end

				// Last stack write lands here, bus released after
				finish: begin
					seq_req.we <= 1'b0;
					state      <= idle;
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_bus_memory.sv
// Stack page and vector page RAM shared by the engine port and the sequencer, registered read
`timescale 1ns/1ns
`default_nettype none

module cpu_bus_memory
	import int_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire           busy,
	input  wire bus_req_t ext_req,
	input  wire bus_req_t seq_req,
	output byte_t         rdata
);

	////////////////////
	// Storage
	////////////////////

	// Page 0x01
	byte_t stack_mem [0:255];
	// Page 0xFF
	byte_t vec_mem [0:255];

	// Active request
	bus_req_t req;
	byte_t    page;
	byte_t    offset;

	// Sequencer owns the bus while busy
	assign req    = busy ? seq_req : ext_req;
	assign page   = req.addr[15:8];
	assign offset = req.addr[7:0];

	////////////////////
	// Write port
	////////////////////

	// Writes outside the two pages are dropped
	always_ff @(posedge clk) begin
		if (req.we) begin
			if (page == stack_page) begin
				stack_mem[offset] <= req.wdata;
			end else if (page == vec_page) begin
				vec_mem[offset] <= req.wdata;
			end
		end
	end

	////////////////////
	// Read port
	////////////////////

	// Data one cycle after the address, old contents on a same-cycle write
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (page == stack_page) begin
			rdata <= stack_mem[offset];
		end else if (page == vec_page) begin
			rdata <= vec_mem[offset];
		end else begin
			// Unbacked pages read zero
			rdata <= '0;
		end
	end

endmodule

`default_nettype wire

//--- source/int_unit_top.sv
// Interrupt unit top level, ties sources, sequencer and bus memory to the engine-side ports
`timescale 1ns/1ns
`default_nettype none

module int_unit_top
	import int_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	// Engine control
	input  wire            start,
	input  wire            is_rti,
	input  wire            halt,
	input  wire cpu_regs_t regs_in,
	output wire cpu_regs_t regs_out,
	output wire            done,
	output wire            busy,
	output wire            ie_dis,
	// Interrupt sources
	input  wire            soft_reset_n,
	input  wire byte_t     ppu_status,
	input  wire byte_t     ppu_ctrl1,
	input  wire            brk,
	input  wire            irq_n,
	// Engine memory port
	input  wire bus_req_t  ext_req,
	output wire byte_t     rdata
);

	// Between sources and sequencer
	wire int_cause_e cause;
	wire int_cause_e fetch_cause;
	wire             vec_fetch;

	// Sequencer side of the bus
	wire bus_req_t seq_req;

	////////////////////
	// Units
	////////////////////

	// I mask taken straight from the engine status
	int_sources u_sources (
		.clk          (clk),
		.rst          (rst),
		.soft_reset_n (soft_reset_n),
		.ppu_status   (ppu_status),
		.ppu_ctrl1    (ppu_ctrl1),
		.brk          (brk),
		.irq_n        (irq_n),
		.status_i     (regs_in.status[flag_i]),
		.vec_fetch    (vec_fetch),
		.fetch_cause  (fetch_cause),
		.cause        (cause)
	);

	int_sequencer u_sequencer (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.is_rti      (is_rti),
		.halt        (halt),
		.regs_in     (regs_in),
		.cause       (cause),
		.rdata       (rdata),
		.regs_out    (regs_out),
		.seq_req     (seq_req),
		.vec_fetch   (vec_fetch),
		.fetch_cause (fetch_cause),
		.busy        (busy),
		.done        (done),
		.ie_dis      (ie_dis)
	);

	// Same read data goes to the engine and the sequencer
	cpu_bus_memory u_memory (
		.clk     (clk),
		.rst     (rst),
		.busy    (busy),
		.ext_req (ext_req),
		.seq_req (seq_req),
		.rdata   (rdata)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Testbench clock and reset source, 4 ns period with reset held low for the first 16 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	// Free running clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Release lines up with a rising edge
	initial begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/int_unit_props.sv
// Concurrent assertions on the interrupt sequencer that are bound into every int_sequencer instance
`timescale 1ns/1ns
`default_nettype none

module int_unit_props
	import int_pkg::*;
(
	input wire             clk,
	input wire             rst,
	input wire             done,
	input wire             busy,
	input wire seq_state_e state,
	input wire bus_req_t   seq_req
);

	// Count of failed assertions for the testbench summary
	int fail_count = 0;

	// Done is a single cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else begin
			$error("done stayed high for a second cycle");
			fail_count++;
		end

	// Idle without done means the bus is released and nothing is written
	idle_not_busy: assert property (@(posedge clk) disable iff (!rst)
		(!done && state == idle) |-> (!busy && !seq_req.we))
		else begin
			$error("bus still held or written while idle");
			fail_count++;
		end

	// Sequencer only ever writes the stack page
	write_in_stack: assert property (@(posedge clk) disable iff (!rst)
		seq_req.we |-> (seq_req.addr[15:8] == stack_page))
		else begin
			$error("sequencer write outside the stack page");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
// Testbench scoreboard that models the interrupt rules and compares DUT registers and stack bytes
`timescale 1ns/1ns
`default_nettype none

module tb_checker
	import int_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire            start,
	input  wire            is_rti,
	input  wire            halt,
	input  wire            brk,
	input  wire            irq_n,
	input  wire            soft_reset_n,
	input  wire byte_t     ppu_status,
	input  wire byte_t     ppu_ctrl1,
	input  wire cpu_regs_t regs_in,
	input  wire cpu_regs_t regs_out,
	input  wire            done,
	input  wire            busy,
	input  wire            ie_dis,
	input  wire bus_req_t  ext_req,
	input  wire byte_t     rdata,
	input  wire            rb_en,
	output int             err_count,
	output int             check_count
);

	// Shadow copies of the two RAM pages
	byte_t stack_sh [0:255];
	byte_t vec_sh [0:255];

	// Pending source model
	logic p_reset;
	logic p_nmi;
	logic p_irq;

	// Operation in flight
	logic       in_op;
	logic       ie_exp;
	logic       clr_wait;
	logic       clr_now;
	logic       entering;
	logic       returning;
	int_cause_e clr_cause;
	int_cause_e cur;
	cpu_regs_t  exp_regs;
	int         cycles;
	int         halts;
	int         base_lat;

	// Readback data trails the address by one edge
	logic  rb_pend;
	byte_t rb_off;
	int    i;

	initial begin
		err_count   = 0;
		check_count = 0;
		for (i = 0; i < 256; i++) begin
			stack_sh[i] = 8'h00;
			vec_sh[i]   = 8'h00;
		end
	end

	////////////////////
	// Reference model
	////////////////////

	// Priority is reset, nmi, brk, then irq under the I mask
	function automatic int_cause_e pick_cause(input logic i_mask);
		if (p_reset) begin
			return cause_reset;
		end
		if (p_nmi) begin
			return cause_nmi;
		end
		if (brk) begin
			return cause_brk;
		end
		if (p_irq && !i_mask) begin
			return cause_irq;
		end
		return cause_none;
	endfunction

	// R is always set and B only for brk
	function automatic byte_t pushed_status(input int_cause_e c, input byte_t s);
		byte_t p;
		p         = s;
		p[flag_r] = 1'b1;
		p[flag_b] = (c == cause_brk);
		return p;
	endfunction

	// Register set expected at done
	function automatic cpu_regs_t expect_regs(input int_cause_e c, input logic rti,
			input logic in_hdl, input cpu_regs_t r);
		cpu_regs_t e;
		addr_t     v;
		byte_t     rb_mask;
		e       = r;
		rb_mask = (8'd1 << flag_r) | (8'd1 << flag_b);
		if (in_hdl) begin
			// Only RTI does anything inside a handler
			if (rti) begin
				e.status = stack_sh[byte_t'(r.sp + 8'd1)] & ~rb_mask;
				e.pc     = {stack_sh[byte_t'(r.sp + 8'd3)], stack_sh[byte_t'(r.sp + 8'd2)]};
				e.sp     = byte_t'(r.sp + 8'd3);
			end
		end else if (c != cause_none) begin
			if (c == cause_reset) begin
				v = vec_reset;
			end else if (c == cause_nmi) begin
				v = vec_nmi;
			end else begin
				v = vec_irq;
			end
			e.pc     = {vec_sh[byte_t'(v[7:0] + 8'd1)], vec_sh[v[7:0]]};
			e.sp     = byte_t'(r.sp - 8'd3);
			e.status = r.status | (8'd1 << flag_i);
			if (c != cause_brk) begin
				e.status = e.status & ~rb_mask;
			end
		end
		return e;
	endfunction

	task automatic report_error(input string msg);
		err_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	////////////////////
	// Compare process
	////////////////////

	always @(posedge clk) begin
		if (!rst) begin
			p_reset  = 1'b0;
			p_nmi    = 1'b0;
			p_irq    = 1'b0;
			in_op    = 1'b0;
			ie_exp   = 1'b0;
			clr_wait = 1'b0;
			rb_pend  = 1'b0;
		end else begin
			// Stack byte readback
			if (rb_pend) begin
				check_count++;
				if (rdata !== stack_sh[rb_off]) begin
					report_error($sformatf("stack byte 0x01%h is %h, expected %h",
						rb_off, rdata, stack_sh[rb_off]));
				end
			end
			rb_pend = rb_en && !ext_req.we;
			rb_off  = ext_req.addr[7:0];

			// Bus is held from the cycle after start up to done
			if (busy !== in_op) begin
				report_error($sformatf("busy %b, expected %b", busy, in_op));
			end

			clr_now = 1'b0;
			if (in_op) begin
				cycles++;
				if (halt) begin
					halts++;
				end else if (clr_wait) begin
					// Vector fetch strobe on the first running cycle
					clr_now  = 1'b1;
					clr_wait = 1'b0;
				end
				if (done) begin
					in_op = 1'b0;
					check_count++;
					if (regs_out !== exp_regs) begin
						report_error($sformatf("regs_out %h, expected %h", regs_out, exp_regs));
					end
					if (cycles != base_lat + halts) begin
						report_error($sformatf("done after %0d cycles, expected %0d",
							cycles, base_lat + halts));
					end
					if (ie_dis !== ie_exp) begin
						report_error($sformatf("ie_dis %b, expected %b", ie_dis, ie_exp));
					end
				end
			end else begin
				if (done) begin
					report_error("done without a start");
				end
				// Engine writes such as the vector preload
				if (ext_req.we) begin
					if (ext_req.addr[15:8] == stack_page) begin
						stack_sh[ext_req.addr[7:0]] = ext_req.wdata;
					end else if (ext_req.addr[15:8] == vec_page) begin
						vec_sh[ext_req.addr[7:0]] = ext_req.wdata;
					end
				end
				if (start && !halt) begin
					cur       = pick_cause(regs_in.status[flag_i]);
					exp_regs  = expect_regs(cur, is_rti, ie_exp, regs_in);
					entering  = !ie_exp && (cur != cause_none);
					returning = ie_exp && is_rti;
					base_lat  = (entering || returning) ? 5 : 1;
					if (entering) begin
						stack_sh[regs_in.sp]                   = regs_in.pc[15:8];
						stack_sh[byte_t'(regs_in.sp - 8'd1)]   = regs_in.pc[7:0];
						stack_sh[byte_t'(regs_in.sp - 8'd2)]   =
							pushed_status(cur, regs_in.status);
						// brk has no latch to clear
						clr_wait  = (cur != cause_brk);
						clr_cause = cur;
						ie_exp    = 1'b1;
					end
					if (returning) begin
						ie_exp = 1'b0;
					end
					in_op  = 1'b1;
					cycles = 0;
					halts  = 0;
				end
			end

			// Clear wins over set in the latches
			if (clr_now && clr_cause == cause_reset) begin
				p_reset = 1'b0;
			end else if (!soft_reset_n) begin
				p_reset = 1'b1;
			end
			if (clr_now && clr_cause == cause_nmi) begin
				p_nmi = 1'b0;
			end else if (ppu_status[7] && ppu_ctrl1[7]) begin
				p_nmi = 1'b1;
			end
			if (clr_now && clr_cause == cause_irq) begin
				p_irq = 1'b0;
			end else if (!irq_n) begin
				p_irq = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_int_unit.sv
// Testbench top for the interrupt unit that drives the engine side and runs the interrupt tests
`timescale 1ns/1ns
`default_nettype none

module tb_int_unit
	import int_pkg::*;
();

	logic clk;
	logic rst;

	// Engine side stimulus
	logic      start;
	logic      is_rti;
	logic      halt;
	logic      brk;
	logic      irq_n;
	logic      soft_reset_n;
	byte_t     ppu_status;
	byte_t     ppu_ctrl1;
	cpu_regs_t regs_in;
	bus_req_t  ext_req;
	// Marks readback cycles for the checker
	logic      rb_en;

	// DUT responses
	wire cpu_regs_t regs_out;
	wire            done;
	wire            busy;
	wire            ie_dis;
	wire byte_t     rdata;

	// Counters
	int err_count;
	int check_count;
	int test_count;
	int failed;
	int err_mark;
	int cycle;
	// Six tests at 40 cycles each plus reset and preload
	int cycle_limit = 40 * 6 + 200;

	logic [31:0] seed = 32'h3c4d;
	logic [31:0] v;
	cpu_regs_t   last_regs;
	cpu_regs_t   hdl_regs;
	cpu_regs_t   r;
	int          i;

	////////////////////
	// Instances
	////////////////////

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	int_unit_top uut (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.is_rti       (is_rti),
		.halt         (halt),
		.regs_in      (regs_in),
		.regs_out     (regs_out),
		.done         (done),
		.busy         (busy),
		.ie_dis       (ie_dis),
		.soft_reset_n (soft_reset_n),
		.ppu_status   (ppu_status),
		.ppu_ctrl1    (ppu_ctrl1),
		.brk          (brk),
		.irq_n        (irq_n),
		.ext_req      (ext_req),
		.rdata        (rdata)
	);

	tb_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.is_rti       (is_rti),
		.halt         (halt),
		.brk          (brk),
		.irq_n        (irq_n),
		.soft_reset_n (soft_reset_n),
		.ppu_status   (ppu_status),
		.ppu_ctrl1    (ppu_ctrl1),
		.regs_in      (regs_in),
		.regs_out     (regs_out),
		.done         (done),
		.busy         (busy),
		.ie_dis       (ie_dis),
		.ext_req      (ext_req),
		.rdata        (rdata),
		.rb_en        (rb_en),
		.err_count    (err_count),
		.check_count  (check_count)
	);

	bind int_sequencer int_unit_props props (
		.clk     (clk),
		.rst     (rst),
		.done    (done),
		.busy    (busy),
		.state   (state),
		.seq_req (seq_req)
	);

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] val);
		seed = xorshift(seed);
		val  = seed;
	endtask

	task automatic random_regs(output cpu_regs_t rr);
		logic [31:0] x;
		draw_random(x);
		rr.pc     = x[15:0];
		rr.status = x[23:16];
		rr.sp     = x[31:24];
	endtask

	task automatic write_byte(input addr_t a, input byte_t d);
		@(posedge clk);
		ext_req <= '{addr: a, wdata: d, we: 1'b1};
	endtask

	// One-cycle pulse on the selected sources
	task automatic pulse_sources(input logic rs, input logic nm, input logic iq);
		@(posedge clk);
		soft_reset_n <= !rs;
		ppu_status   <= {nm, 7'h00};
		irq_n        <= !iq;
		@(posedge clk);
		soft_reset_n <= 1'b1;
		ppu_status   <= 8'h00;
		irq_n        <= 1'b1;
	endtask

	// Start strobe, optional halt window, then wait for done
	task automatic run_op(input cpu_regs_t rr, input logic rti, input logic b,
			input int halt_at, input int halt_len);
		@(posedge clk);
		regs_in <= rr;
		is_rti  <= rti;
		brk     <= b;
		start   <= 1'b1;
		@(posedge clk);
		start  <= 1'b0;
		is_rti <= 1'b0;
		brk    <= 1'b0;
		if (halt_len > 0) begin
			repeat (halt_at) @(posedge clk);
			halt <= 1'b1;
			repeat (halt_len) @(posedge clk);
			halt <= 1'b0;
		end
		while (!done) @(posedge clk);
		last_regs = regs_out;
	endtask

	// Read the three stack bytes below the old sp through the engine port
	task automatic read_back(input byte_t sp);
		int k;
		@(posedge clk);
		rb_en <= 1'b1;
		for (k = 0; k < 3; k++) begin
			ext_req <= '{addr: {stack_page, byte_t'(sp - k)}, wdata: 8'h00, we: 1'b0};
			@(posedge clk);
		end
		rb_en <= 1'b0;
		@(posedge clk);
	endtask

	// Entry, readback, RTI with the same halt window on both
	task automatic service(input cpu_regs_t rr, input logic b, input int halt_at,
			input int halt_len);
		cpu_regs_t hdl;
		run_op(rr, 1'b0, b, halt_at, halt_len);
		hdl = last_regs;
		read_back(rr.sp);
		run_op(hdl, 1'b1, 1'b0, halt_at, halt_len);
	endtask

	task automatic end_test(input string name);
		@(negedge clk);
		test_count++;
		if (err_count == err_mark) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed++;
			$display("test %0d %s: FAILED with %0d errors", test_count, name,
				err_count - err_mark);
		end
		err_mark = err_count;
	endtask

	////////////////////
	// Timeout
	////////////////////

	initial begin
		cycle = 0;
		while (cycle < cycle_limit) begin
			@(posedge clk);
			cycle++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

	////////////////////
	// Tests
	////////////////////

	initial begin
		start        = 1'b0;
		is_rti       = 1'b0;
		halt         = 1'b0;
		brk          = 1'b0;
		irq_n        = 1'b1;
		soft_reset_n = 1'b1;
		ppu_status   = 8'h00;
		// NMI enable stays on and only vblank is pulsed
		ppu_ctrl1    = 8'h80;
		regs_in      = '0;
		ext_req      = '0;
		rb_en        = 1'b0;
		test_count   = 0;
		failed       = 0;
		err_mark     = 0;

		@(posedge rst);
		// Random vectors at FFFA to FFFF
		for (i = 0; i < 6; i++) begin
			draw_random(v);
			write_byte(vec_nmi + addr_t'(i), v[7:0]);
		end
		@(posedge clk);
		ext_req.we <= 1'b0;

		// Nothing pending so the start passes through in one cycle
		random_regs(r);
		run_op(r, 1'b0, 1'b0, 0, 0);
		end_test("no cause");

		random_regs(r);
		r.status[flag_i] = 1'b0;
		pulse_sources(1'b0, 1'b0, 1'b1);
		service(r, 1'b0, 0, 0);
		end_test("irq entry");

		// Masked irq stays pending while brk ignores I
		random_regs(r);
		r.status[flag_i] = 1'b1;
		pulse_sources(1'b0, 1'b0, 1'b1);
		run_op(r, 1'b0, 1'b0, 0, 0);
		service(r, 1'b1, 0, 0);
		end_test("irq masked, brk taken");

		// Reset entry, a plain start inside the handler, then nmi and irq in turn
		random_regs(r);
		r.status[flag_i] = 1'b0;
		pulse_sources(1'b1, 1'b1, 1'b1);
		run_op(r, 1'b0, 1'b0, 0, 0);
		hdl_regs = last_regs;
		read_back(r.sp);
		random_regs(r);
		run_op(r, 1'b0, 1'b0, 0, 0);
		run_op(hdl_regs, 1'b1, 1'b0, 0, 0);
		for (i = 0; i < 3; i++) begin
			random_regs(r);
			r.status[flag_i] = 1'b0;
			if (i < 2) begin
				service(r, 1'b0, 0, 0);
			end else begin
				run_op(r, 1'b0, 1'b0, 0, 0);
			end
		end
		end_test("priority order");

		random_regs(r);
		r.status[flag_i] = 1'b0;
		service(r, 1'b1, 0, 0);
		end_test("rti return");

		// Halt during the PCH write and during the stack pops
		random_regs(r);
		pulse_sources(1'b0, 1'b1, 1'b0);
		service(r, 1'b0, 2, 3);
		end_test("halt during entry and return");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			test_count, failed, check_count, err_count, uut.u_sequencer.props.fail_count);
		if (failed == 0 && err_count == 0 && uut.u_sequencer.props.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
source/int_pkg.sv
source/int_sources.sv
source/int_sequencer.sv
source/cpu_bus_memory.sv
source/int_unit_top.sv
testbench/tb_clock.sv
testbench/int_unit_props.sv
testbench/tb_checker.sv
testbench/tb_int_unit.sv

//--- Bender.yml
package:
  name: int_unit

sources:
  # Package first, the design units import it
  - source/int_pkg.sv
  - source/int_sources.sv
  - source/int_sequencer.sv
  - source/cpu_bus_memory.sv
  - source/int_unit_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/int_unit_props.sv
      - testbench/tb_checker.sv
      - testbench/tb_int_unit.sv
